//--- src/rv_isa_pkg.sv
// RV64 ISA definitions
`default_nettype none

package rv_isa_pkg;

    localparam int XLEN = 64;

    typedef logic [XLEN-1:0] xlen_t;   // data and address word
    typedef logic [31:0]     inst_t;   // raw instruction
    typedef logic [4:0]      reg_addr_t;

    // boot address, matches the memory map of the sim
    localparam xlen_t RESET_PC = 64'h0000_0000_8000_0000;

    // major opcodes, bits [6:0]
    localparam logic [6:0] OPC_OP_IMM = 7'b001_0011;
    localparam logic [6:0] OPC_OP     = 7'b011_0011;
    localparam logic [6:0] OPC_LUI    = 7'b011_0111;
    localparam logic [6:0] OPC_AUIPC  = 7'b001_0111;
    localparam logic [6:0] OPC_BRANCH = 7'b110_0011;
    localparam logic [6:0] OPC_JAL    = 7'b110_1111;
    localparam logic [6:0] OPC_JALR   = 7'b110_0111;

    // funct3 values
    localparam logic [2:0] F3_ADD = 3'b000;   // also jalr
    localparam logic [2:0] F3_BEQ = 3'b000;
    localparam logic [2:0] F3_BNE = 3'b001;

    // funct7 values
    localparam logic [6:0] F7_ADD = 7'b000_0000;
    localparam logic [6:0] F7_SUB = 7'b010_0000;

endpackage

`default_nettype wire

//--- src/rv_ctrl_pkg.sv
// Core control encodings
`default_nettype none

package rv_ctrl_pkg;

    typedef enum logic {
        ALU_ADD,
        ALU_SUB
    } alu_op_e;

    // immediate layout picked by decode
    typedef enum logic [1:0] {
        IMM_I,
        IMM_U,
        IMM_B,
        IMM_J
    } imm_sel_e;

    // alu operand pair, first named operand goes to port a
    typedef enum logic [1:0] {
        SRC_REG_REG,
        SRC_REG_IMM,
        SRC_ZERO_IMM,   // lui
        SRC_PC_IMM      // auipc
    } src_sel_e;

    typedef enum logic [1:0] {
        PC_SEQ,
        PC_BRANCH,
        PC_JAL,
        PC_JALR
    } pc_sel_e;

endpackage

`default_nettype wire

//--- src/rv_decode.sv
// Instruction decoder
`default_nettype none

module rv_decode (
    input  wire rv_isa_pkg::inst_t     inst,
    output rv_isa_pkg::reg_addr_t      rs1,
    output rv_isa_pkg::reg_addr_t      rs2,
    output rv_isa_pkg::reg_addr_t      rd,
    output logic                       reg_wen,
    output rv_isa_pkg::xlen_t          imm,
    output rv_ctrl_pkg::alu_op_e       alu_op,
    output rv_ctrl_pkg::src_sel_e      src_sel,
    output rv_ctrl_pkg::pc_sel_e       pc_sel,
    output logic                       branch_ne,
    output logic                       illegal
);
    import rv_isa_pkg::*;
    import rv_ctrl_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    imm_sel_e   imm_sel;

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];

    assign rs1 = inst[19:15];
    assign rs2 = inst[24:20];
    assign rd  = inst[11:7];

    always_comb begin
        reg_wen   = 1'b0;   // safe defaults, also the illegal case
        alu_op    = ALU_ADD;
        src_sel   = SRC_REG_IMM;
        pc_sel    = PC_SEQ;
        imm_sel   = IMM_I;
        branch_ne = 1'b0;
        illegal   = 1'b0;
        case (opcode)
            OPC_OP_IMM: begin
                if (funct3 == F3_ADD) reg_wen = 1'b1;   // addi
                else                  illegal = 1'b1;
            end
            OPC_OP: begin
                src_sel = SRC_REG_REG;
                if (funct3 == F3_ADD && funct7 == F7_ADD) begin
                    reg_wen = 1'b1;
                end else if (funct3 == F3_ADD && funct7 == F7_SUB) begin
                    reg_wen = 1'b1;
                    alu_op  = ALU_SUB;
                end else begin
                    illegal = 1'b1;
                end
            end
            OPC_LUI: begin
                reg_wen = 1'b1;
                imm_sel = IMM_U;
                src_sel = SRC_ZERO_IMM;
            end
            OPC_AUIPC: begin
                reg_wen = 1'b1;
                imm_sel = IMM_U;
                src_sel = SRC_PC_IMM;
            end
            OPC_BRANCH: begin
                imm_sel = IMM_B;
                case (funct3)
                    F3_BEQ: pc_sel = PC_BRANCH;
                    F3_BNE: begin
                        pc_sel    = PC_BRANCH;
                        branch_ne = 1'b1;
                    end
                    default: illegal = 1'b1;
                endcase
            end
            OPC_JAL: begin
                reg_wen = 1'b1;
                imm_sel = IMM_J;
                pc_sel  = PC_JAL;
            end
            OPC_JALR: begin
                if (funct3 == F3_ADD) begin
                    reg_wen = 1'b1;
                    pc_sel  = PC_JALR;
                end else begin
                    illegal = 1'b1;
                end
            end
            default: illegal = 1'b1;
        endcase
    end

    // sign-extended immediate
    always_comb begin
        case (imm_sel)
            IMM_I:   imm = {{(XLEN-12){inst[31]}}, inst[31:20]};
            IMM_U:   imm = {{(XLEN-32){inst[31]}}, inst[31:12], 12'b0};
            IMM_B:   imm = {{(XLEN-13){inst[31]}}, inst[31], inst[7], inst[30:25],
                            inst[11:8], 1'b0};
            IMM_J:   imm = {{(XLEN-21){inst[31]}}, inst[31], inst[19:12], inst[20],
                            inst[30:21], 1'b0};
            default: imm = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- src/rv_reg_file.sv
// Integer register file
`default_nettype none

module rv_reg_file (
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire                         wen,
    input  wire rv_isa_pkg::reg_addr_t  waddr,
    input  wire rv_isa_pkg::xlen_t      wdata,
    input  wire rv_isa_pkg::reg_addr_t  rs1,
    input  wire rv_isa_pkg::reg_addr_t  rs2,
    output rv_isa_pkg::xlen_t           rs1_data,
    output rv_isa_pkg::xlen_t           rs2_data
);
    import rv_isa_pkg::*;

    xlen_t regs [1:31];   // x0 has no storage

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wen && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    // async read ports
    assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
    assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

`default_nettype wire

//--- src/rv_execute.sv
// ALU and branch compare
`default_nettype none

module rv_execute (
    input  wire rv_isa_pkg::xlen_t      pc,
    input  wire rv_isa_pkg::xlen_t      rs1_data,
    input  wire rv_isa_pkg::xlen_t      rs2_data,
    input  wire rv_isa_pkg::xlen_t      imm,
    input  wire rv_ctrl_pkg::alu_op_e   alu_op,
    input  wire rv_ctrl_pkg::src_sel_e  src_sel,
    input  wire                         branch_ne,
    output rv_isa_pkg::xlen_t           alu_res,
    output logic                        cond_true
);
    import rv_isa_pkg::*;
    import rv_ctrl_pkg::*;

    xlen_t op_a;
    xlen_t op_b;
    logic  regs_equal;

    always_comb begin
        case (src_sel)
            SRC_REG_REG: begin
                op_a = rs1_data;
                op_b = rs2_data;
            end
            SRC_REG_IMM: begin
                op_a = rs1_data;
                op_b = imm;
            end
            SRC_ZERO_IMM: begin
                op_a = '0;   // lui passes the immediate
                op_b = imm;
            end
            SRC_PC_IMM: begin
                op_a = pc;
                op_b = imm;
            end
            default: begin
                op_a = rs1_data;
                op_b = imm;
            end
        endcase
    end

    assign alu_res = (alu_op == ALU_SUB) ? (op_a - op_b) : (op_a + op_b);

    // beq takes on equal, bne on not equal
    assign regs_equal = (rs1_data == rs2_data);
    assign cond_true  = regs_equal ^ branch_ne;

endmodule

`default_nettype wire

//--- src/rv_result.sv
// PC and writeback select
`default_nettype none

module rv_result (
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire rv_isa_pkg::xlen_t      alu_res,
    input  wire                         cond_true,
    input  wire rv_isa_pkg::xlen_t      imm,
    input  wire rv_isa_pkg::xlen_t      rs1_data,
    input  wire rv_ctrl_pkg::pc_sel_e   pc_sel,
    input  wire                         reg_wen,
    input  wire rv_isa_pkg::reg_addr_t  rd,
    output rv_isa_pkg::xlen_t           pc,
    output logic                        wen,
    output rv_isa_pkg::reg_addr_t       waddr,
    output rv_isa_pkg::xlen_t           wdata
);
    import rv_isa_pkg::*;
    import rv_ctrl_pkg::*;

    logic  run;   // low for one cycle after reset
    logic  is_jump;
    xlen_t pc_plus4;
    xlen_t pc_target;
    xlen_t jalr_target;
    xlen_t next_pc;

    assign pc_plus4    = pc + xlen_t'(4);
    assign pc_target   = pc + imm;
    assign jalr_target = (rs1_data + imm) & ~xlen_t'(1);

    always_comb begin
        case (pc_sel)
            PC_BRANCH: next_pc = cond_true ? pc_target : pc_plus4;
            PC_JAL:    next_pc = pc_target;
            PC_JALR:   next_pc = jalr_target;
            default:   next_pc = pc_plus4;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc  <= RESET_PC;
            run <= 1'b0;
        end else begin
            run <= 1'b1;
            if (run) pc <= next_pc;   // hold pc over the idle cycle
        end
    end

    assign is_jump = (pc_sel == PC_JAL) || (pc_sel == PC_JALR);

    assign wen   = reg_wen & run;
    assign waddr = rd;
    assign wdata = is_jump ? pc_plus4 : alu_res;   // link address for jumps

endmodule

`default_nettype wire

//--- src/rv_core_top.sv
// Single-cycle RV64 core
`default_nettype none

module rv_core_top (
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire rv_isa_pkg::inst_t      inst,
    output rv_isa_pkg::xlen_t           pc,
    output logic                        illegal,
    output logic                        commit_wen,
    output rv_isa_pkg::reg_addr_t       commit_waddr,
    output rv_isa_pkg::xlen_t           commit_wdata
);
    import rv_isa_pkg::*;
    import rv_ctrl_pkg::*;

    reg_addr_t rs1;
    reg_addr_t rs2;
    reg_addr_t rd;
    logic      reg_wen;
    xlen_t     imm;
    alu_op_e   alu_op;
    src_sel_e  src_sel;
    pc_sel_e   pc_sel;
    logic      branch_ne;

    xlen_t     rs1_data;
    xlen_t     rs2_data;
    xlen_t     alu_res;
    logic      cond_true;

    logic      wen;   // regfile write port
    reg_addr_t waddr;
    xlen_t     wdata;

    rv_decode u_decode (
        .inst      (inst),
        .rs1       (rs1),
        .rs2       (rs2),
        .rd        (rd),
        .reg_wen   (reg_wen),
        .imm       (imm),
        .alu_op    (alu_op),
        .src_sel   (src_sel),
        .pc_sel    (pc_sel),
        .branch_ne (branch_ne),
        .illegal   (illegal)
    );

    rv_reg_file u_reg_file (
        .clk      (clk),
        .rst_n    (rst_n),
        .wen      (wen),
        .waddr    (waddr),
        .wdata    (wdata),
        .rs1      (rs1),
        .rs2      (rs2),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    rv_execute u_execute (
        .pc        (pc),
        .rs1_data  (rs1_data),
        .rs2_data  (rs2_data),
        .imm       (imm),
        .alu_op    (alu_op),
        .src_sel   (src_sel),
        .branch_ne (branch_ne),
        .alu_res   (alu_res),
        .cond_true (cond_true)
    );

    rv_result u_result (
        .clk       (clk),
        .rst_n     (rst_n),
        .alu_res   (alu_res),
        .cond_true (cond_true),
        .imm       (imm),
        .rs1_data  (rs1_data),
        .pc_sel    (pc_sel),
        .reg_wen   (reg_wen),
        .rd        (rd),
        .pc        (pc),
        .wen       (wen),
        .waddr     (waddr),
        .wdata     (wdata)
    );

    // commit trace mirrors the write port
    assign commit_wen   = wen;
    assign commit_waddr = waddr;
    assign commit_wdata = wdata;

endmodule

`default_nettype wire

//--- verification/tb_rv_core.sv
// RV64 core testbench
`default_nettype none

module tb_rv_core;
    timeunit 1ns;
    timeprecision 100ps;

    import rv_isa_pkg::*;

    localparam int    PROG_LEN       = 23;
    localparam int    TIMEOUT_CYCLES = 16 + 2 * PROG_LEN + 50;
    localparam inst_t NOP            = 32'h0000_0013;   // addi x0, x0, 0
    localparam xlen_t END_PC         = RESET_PC + xlen_t'(4 * PROG_LEN);

    logic      clk;
    logic      rst_n;
    inst_t     inst;
    xlen_t     pc;
    logic      illegal;
    logic      commit_wen;
    reg_addr_t commit_waddr;
    xlen_t     commit_wdata;

    // reference model state
    inst_t     prog [PROG_LEN];
    xlen_t     m_regs [32] = '{default: '0};
    xlen_t     m_pc        = RESET_PC;
    logic      m_run       = 1'b0;   // low until the first edge after reset
    inst_t     cur_inst    = NOP;
    logic      exp_wen     = 1'b0;
    reg_addr_t exp_waddr   = '0;
    xlen_t     exp_wdata   = '0;
    xlen_t     exp_next    = RESET_PC;
    logic      exp_illegal = 1'b0;
    string     cur_name    = "reset";
    int        errors      = 0;
    int        cycles      = 0;
    int        seed        = 32'h7944;

    rv_core_top u_dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .inst         (inst),
        .pc           (pc),
        .illegal      (illegal),
        .commit_wen   (commit_wen),
        .commit_waddr (commit_waddr),
        .commit_wdata (commit_wdata)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic inst_t enc_i(logic [11:0] imm, reg_addr_t rs1, logic [2:0] f3,
                                    reg_addr_t rd, logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic inst_t enc_r(logic [6:0] f7, reg_addr_t rs2, reg_addr_t rs1,
                                    logic [2:0] f3, reg_addr_t rd, logic [6:0] opc);
        return {f7, rs2, rs1, f3, rd, opc};
    endfunction

    function automatic inst_t enc_u(logic [19:0] imm, reg_addr_t rd, logic [6:0] opc);
        return {imm, rd, opc};
    endfunction

    function automatic inst_t enc_b(logic [12:0] off, reg_addr_t rs2, reg_addr_t rs1,
                                    logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OPC_BRANCH};
    endfunction

    function automatic inst_t enc_j(logic [20:0] off, reg_addr_t rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, OPC_JAL};
    endfunction

    // instruction memory, nop outside the program
    function automatic inst_t fetch(xlen_t addr);
        xlen_t idx;
        idx = (addr - RESET_PC) >> 2;
        if (addr >= RESET_PC && idx < 64'(PROG_LEN)) begin
            return prog[idx[4:0]];
        end
        return NOP;
    endfunction

    // expected commit and next pc for cur_inst
    task automatic model_eval();
        logic [6:0] opc;
        logic [2:0] f3;
        logic [6:0] f7;
        xlen_t      a;
        xlen_t      b;
        xlen_t      imm_i;
        xlen_t      imm_u;
        xlen_t      imm_b;
        xlen_t      imm_j;
        xlen_t      pc4;
        xlen_t      jalr_sum;
        logic       taken;
        opc      = cur_inst[6:0];
        f3       = cur_inst[14:12];
        f7       = cur_inst[31:25];
        a        = m_regs[cur_inst[19:15]];
        b        = m_regs[cur_inst[24:20]];
        imm_i    = xlen_t'($signed(cur_inst[31:20]));
        imm_u    = xlen_t'($signed({cur_inst[31:12], 12'h000}));
        imm_b    = xlen_t'($signed({cur_inst[31], cur_inst[7], cur_inst[30:25],
                                    cur_inst[11:8], 1'b0}));
        imm_j    = xlen_t'($signed({cur_inst[31], cur_inst[19:12], cur_inst[20],
                                    cur_inst[30:21], 1'b0}));
        pc4      = m_pc + 64'd4;
        jalr_sum = a + imm_i;
        taken    = 1'b0;
        exp_wen     = 1'b0;
        exp_waddr   = cur_inst[11:7];
        exp_wdata   = '0;
        exp_illegal = 1'b0;
        exp_next    = pc4;
        cur_name    = "illegal";
        case (opc)
            OPC_OP_IMM: begin
                exp_illegal = (f3 != F3_ADD);
                exp_wen     = (f3 == F3_ADD);
                exp_wdata   = a + imm_i;
                cur_name    = (cur_inst[11:7] == '0) ? "addi to x0" : "addi";
            end
            OPC_OP: begin
                if (f3 == F3_ADD && f7 == F7_ADD) begin
                    exp_wen   = 1'b1;
                    exp_wdata = a + b;
                    cur_name  = "add";
                end else if (f3 == F3_ADD && f7 == F7_SUB) begin
                    exp_wen   = 1'b1;
                    exp_wdata = a - b;
                    cur_name  = "sub";
                end else begin
                    exp_illegal = 1'b1;
                end
            end
            OPC_LUI: begin
                exp_wen   = 1'b1;
                exp_wdata = imm_u;
                cur_name  = "lui";
            end
            OPC_AUIPC: begin
                exp_wen   = 1'b1;
                exp_wdata = m_pc + imm_u;
                cur_name  = "auipc";
            end
            OPC_BRANCH: begin
                if (f3 == F3_BEQ || f3 == F3_BNE) begin
                    taken    = (f3 == F3_BEQ) ? (a == b) : (a != b);
                    exp_next = taken ? m_pc + imm_b : pc4;
                    cur_name = taken ? "branch taken" : "branch not taken";
                end else begin
                    exp_illegal = 1'b1;
                end
            end
            OPC_JAL: begin
                exp_wen   = 1'b1;
                exp_wdata = pc4;   // link address
                exp_next  = m_pc + imm_j;
                cur_name  = "jal";
            end
            OPC_JALR: begin
                exp_illegal = (f3 != F3_ADD);
                exp_wen     = (f3 == F3_ADD);
                exp_wdata   = pc4;
                exp_next    = exp_illegal ? pc4 : {jalr_sum[63:1], 1'b0};
                cur_name    = "jalr";
            end
            default: exp_illegal = 1'b1;
        endcase
        if (!m_run) begin
            exp_wen  = 1'b0;
            cur_name = "reset";
        end
    endtask

    // model steps on the same edge as the DUT, then drives the next fetch
    always @(posedge clk) begin
        if (rst_n && m_run) begin
            if (exp_wen && exp_waddr != '0) m_regs[exp_waddr] = exp_wdata;
            m_pc = exp_next;
        end
        if (rst_n) m_run = 1'b1;
        cur_inst = fetch(m_pc);
        inst <= cur_inst;
        model_eval();
    end

    task automatic report_error(input string test, input string field,
                                input xlen_t expected, input xlen_t actual);
        errors++;
        $display("** Error %s: %s expected %h, actual %h (pc %h, %0t)",
                 test, field, expected, actual, m_pc, $time);
    endtask

    // checks on the falling edge, outputs settled
    pc_check: assert property (@(negedge clk) pc == m_pc)
        else report_error(cur_name, "pc", m_pc, pc);
    wen_check: assert property (@(negedge clk) commit_wen == exp_wen)
        else report_error(cur_name, "commit_wen", xlen_t'(exp_wen), xlen_t'(commit_wen));
    waddr_check: assert property (@(negedge clk) !exp_wen || commit_waddr == exp_waddr)
        else report_error(cur_name, "commit_waddr", xlen_t'(exp_waddr),
                          xlen_t'(commit_waddr));
    wdata_check: assert property (@(negedge clk) !exp_wen || commit_wdata == exp_wdata)
        else report_error(cur_name, "commit_wdata", exp_wdata, commit_wdata);
    illegal_check: assert property (@(negedge clk) illegal == exp_illegal)
        else report_error(cur_name, "illegal", xlen_t'(exp_illegal), xlen_t'(illegal));

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout reached after %0d cycles, program did not finish", cycles);
            $display("TESTS FAILED");
            $finish;
        end
    end

    initial begin
        logic [31:0] rnd;
        rst_n <= 1'b0;
        inst  <= NOP;
        rnd = $random(seed);
        prog[0]  = enc_i(rnd[11:0], 5'd0, F3_ADD, 5'd1, OPC_OP_IMM);
        rnd = $random(seed);
        prog[1]  = enc_i({rnd[11:1], 1'b1}, 5'd1, F3_ADD, 5'd2, OPC_OP_IMM);   // x2 != x1
        rnd = $random(seed);
        prog[2]  = enc_u(rnd[19:0], 5'd3, OPC_LUI);
        prog[3]  = enc_r(F7_ADD, 5'd2, 5'd1, F3_ADD, 5'd4, OPC_OP);
        prog[4]  = enc_r(F7_SUB, 5'd3, 5'd4, F3_ADD, 5'd5, OPC_OP);
        prog[5]  = enc_u(20'h12345, 5'd6, OPC_AUIPC);
        prog[6]  = enc_i(12'd5, 5'd1, F3_ADD, 5'd0, OPC_OP_IMM);
        prog[7]  = enc_r(F7_ADD, 5'd5, 5'd0, F3_ADD, 5'd7, OPC_OP);
        prog[8]  = enc_b(13'd8, 5'd1, 5'd1, F3_BEQ);   // taken
        prog[9]  = enc_i(12'd1, 5'd0, F3_ADD, 5'd8, OPC_OP_IMM);
        prog[10] = enc_b(13'd8, 5'd1, 5'd1, F3_BNE);   // not taken
        prog[11] = enc_b(13'd8, 5'd2, 5'd1, F3_BNE);   // taken
        prog[12] = enc_i(12'd2, 5'd0, F3_ADD, 5'd8, OPC_OP_IMM);
        prog[13] = enc_b(13'd8, 5'd2, 5'd1, F3_BEQ);   // not taken
        prog[14] = enc_j(21'd8, 5'd9);
        prog[15] = enc_i(12'd3, 5'd0, F3_ADD, 5'd8, OPC_OP_IMM);
        prog[16] = enc_u(20'd0, 5'd10, OPC_AUIPC);
        prog[17] = enc_i(12'd13, 5'd10, F3_ADD, 5'd11, OPC_JALR);   // odd target
        prog[18] = enc_i(12'd4, 5'd0, F3_ADD, 5'd8, OPC_OP_IMM);
        prog[19] = enc_r(7'd0, 5'd2, 5'd1, 3'b100, 5'd12, OPC_OP);   // xor
        prog[20] = enc_i(12'd0, 5'd1, 3'b011, 5'd13, 7'b000_0011);   // ld
        prog[21] = enc_r(F7_ADD, 5'd11, 5'd9, F3_ADD, 5'd14, OPC_OP);
        prog[22] = enc_r(F7_SUB, 5'd1, 5'd0, F3_ADD, 5'd15, OPC_OP);
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
        while (m_pc != END_PC) @(negedge clk);
        repeat (2) @(negedge clk);   // a nop past the program end
        @(posedge clk);
        $display("run complete, %0d errors", errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- files.f
src/rv_isa_pkg.sv
src/rv_ctrl_pkg.sv
src/rv_decode.sv
src/rv_reg_file.sv
src/rv_execute.sv
src/rv_result.sv
src/rv_core_top.sv
verification/tb_rv_core.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_rv_core
SEED      ?= 0
LOG       ?= sim.log
BUILD_DIR ?= obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) --binary --assert --timescale 1ns/100ps --top-module $(TOP) \
		-Mdir $(BUILD_DIR) -f files.f

run: compile
	./$(BUILD_DIR)/V$(TOP) +verilator+seed+$(SEED) 2>&1 | tee $(LOG)
	@if grep -q "TESTS FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "TESTS PASSED" $(LOG) || { echo "simulation ended without a result"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
